// File: Bender.yml
package:
  name: csr_unit

sources:
  - files:
      - hw/csr_pkg.sv
      - hw/csr_access.sv
      - hw/csr_counters.sv
      - hw/csr_regfile.sv
      - hw/csr_top.sv
  - target: simulation
    files:
      - tb/tb_csr_top.sv

// File: filelist.f
hw/csr_pkg.sv
hw/csr_access.sv
hw/csr_counters.sv
hw/csr_regfile.sv
hw/csr_top.sv
tb/tb_csr_top.sv

// File: hw/csr_access.sv
`timescale 1ns/1ps
`default_nettype none

module csr_access #(
    parameter int XLEN = 32
) (
    input  csr_pkg::csr_op_e    csr_op,
    input  logic                csr_src,
    input  logic [XLEN-1:0]     rs1_data,
    input  logic [XLEN-1:0]     imm_csr,
    input  logic [XLEN-1:0]     csr_read,
    input  logic                inst_valid,
    output logic                csr_we,
    output logic [XLEN-1:0]     csr_wdata
);

    logic [XLEN-1:0] operand;

    // zimm or rs1
    assign operand = csr_src ? imm_csr : rs1_data;

    always_comb begin
        case (csr_op)
            csr_pkg::CSR_RW: begin
                csr_wdata = operand;
            end
            csr_pkg::CSR_RS: begin
                csr_wdata = csr_read | operand;
            end
            csr_pkg::CSR_RC: begin
                csr_wdata = csr_read & ~operand;
            end
            default: begin
                // no op, old value passes through
                csr_wdata = csr_read;
            end
        endcase
    end

    assign csr_we = inst_valid && (csr_op != csr_pkg::CSR_NONE);

    // decode must hand over a clean op with every valid instruction
    always_comb begin
        if (inst_valid) begin
            a_op_known: assert #0 (!$isunknown(csr_op))
                else $error("csr_access: csr_op unknown on a valid instruction");
        end
    end

endmodule

`default_nettype wire

// File: hw/csr_counters.sv
`timescale 1ns/1ps
`default_nettype none

module csr_counters #(
    parameter int XLEN = 32
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_valid,
    input  logic                csr_we,
    input  logic [11:0]         csr_index,
    input  logic [XLEN-1:0]     csr_wdata,
    output logic [XLEN-1:0]     mcycle,
    output logic [XLEN-1:0]     minstret
);

    logic we_mcycle;
    logic we_minstret;

    assign we_mcycle   = csr_we && (csr_index == csr_pkg::CSR_MCYCLE);
    assign we_minstret = csr_we && (csr_index == csr_pkg::CSR_MINSTRET);

    // free-running cycle count
    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle <= '0;
        end else if (we_mcycle) begin
            mcycle <= csr_wdata;
        end else begin
            mcycle <= mcycle + XLEN'(1);
        end
    end

    // one per valid instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            minstret <= '0;
        end else if (we_minstret) begin
            minstret <= csr_wdata;
        end else if (inst_valid) begin
            minstret <= minstret + XLEN'(1);
        end
    end

endmodule

`default_nettype wire

// File: hw/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // machine-mode csr addresses
    typedef enum logic [11:0] {
        CSR_MSTATUS   = 12'h300,
        CSR_MISA      = 12'h301,
        CSR_MIE       = 12'h304,
        CSR_MTVEC     = 12'h305,
        CSR_MSCRATCH  = 12'h340,
        CSR_MEPC      = 12'h341,
        CSR_MCAUSE    = 12'h342,
        CSR_MIP       = 12'h344,
        CSR_MCYCLE    = 12'hb00,
        CSR_MINSTRET  = 12'hb02,
        CSR_MVENDORID = 12'hf11,
        CSR_MARCHID   = 12'hf12,
        CSR_MIMPID    = 12'hf13,
        CSR_MHARTID   = 12'hf14
    } csr_addr_e;

    // operation field from decode
    typedef enum logic [1:0] {
        CSR_NONE = 2'b00,
        CSR_RW   = 2'b01,
        CSR_RS   = 2'b10,
        CSR_RC   = 2'b11
    } csr_op_e;

    // exception and interrupt cause codes
    localparam int unsigned CAUSE_ECALL_M     = 11;
    localparam int unsigned CAUSE_BREAKPOINT  = 3;
    localparam int unsigned CAUSE_MTIMER_CODE = 7;

    // mstatus fields
    localparam int unsigned MSTATUS_MIE_BIT  = 3;
    localparam int unsigned MSTATUS_MPIE_BIT = 7;

    // machine-only core, so mpp stays at M
    localparam logic [1:0] MSTATUS_RESET_MPP = 2'b11;

    // timer bits in mip and mie
    localparam int unsigned MIP_MTIP_BIT = 7;
    localparam int unsigned MIE_MTIE_BIT = 7;

endpackage

`default_nettype wire

// File: hw/csr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module csr_regfile #(
    parameter int XLEN = 32
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_valid,
    input  logic [11:0]         csr_index,
    input  logic                csr_we,
    input  logic [XLEN-1:0]     csr_wdata,
    input  logic [XLEN-1:0]     inst_addr,
    input  logic                inst_trap,
    input  logic                inst_ecall,
    input  logic                inst_ebreak,
    input  logic                inst_mret,
    input  logic                clint_mtip,
    input  logic [XLEN-1:0]     mcycle,
    input  logic [XLEN-1:0]     minstret,
    output logic [XLEN-1:0]     csr_read,
    output logic                csr_trap,
    output logic [XLEN-1:0]     csr_epc,
    output logic [XLEN-1:0]     csr_tvec
);

    localparam logic [XLEN-1:0] MSTATUS_WMASK =
        (XLEN'(1) << csr_pkg::MSTATUS_MIE_BIT) | (XLEN'(1) << csr_pkg::MSTATUS_MPIE_BIT);
    localparam logic [XLEN-1:0] MSTATUS_MPP = XLEN'(csr_pkg::MSTATUS_RESET_MPP) << 11;
    localparam logic [XLEN-1:0] MTIP_MASK = XLEN'(1) << csr_pkg::MIP_MTIP_BIT;
    localparam logic [XLEN-1:0] MTIE_MASK = XLEN'(1) << csr_pkg::MIE_MTIE_BIT;
    localparam logic [XLEN-1:0] MTIMER_CAUSE =
        (XLEN'(1) << (XLEN - 1)) | XLEN'(csr_pkg::CAUSE_MTIMER_CODE);

    // RV32I or RV64I, no extensions
    localparam logic [1:0] MISA_MXL = (XLEN == 64) ? 2'd2 : 2'd1;
    localparam logic [XLEN-1:0] MISA_VAL = {MISA_MXL, {(XLEN-28){1'b0}}, 26'h100};

    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mip;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mscratch;

    logic trap_en;
    logic ret_en;
    logic we_mstatus;
    logic we_mtvec;
    logic we_mepc;
    logic we_mcause;
    logic we_mip;
    logic we_mie;
    logic we_mscratch;

    assign trap_en = inst_valid && inst_trap;
    assign ret_en  = inst_valid && inst_mret;

    assign we_mstatus  = csr_we && (csr_index == csr_pkg::CSR_MSTATUS);
    assign we_mtvec    = csr_we && (csr_index == csr_pkg::CSR_MTVEC);
    assign we_mepc     = csr_we && (csr_index == csr_pkg::CSR_MEPC);
    assign we_mcause   = csr_we && (csr_index == csr_pkg::CSR_MCAUSE);
    assign we_mip      = csr_we && (csr_index == csr_pkg::CSR_MIP);
    assign we_mie      = csr_we && (csr_index == csr_pkg::CSR_MIE);
    assign we_mscratch = csr_we && (csr_index == csr_pkg::CSR_MSCRATCH);

    // software write wins over trap and mret
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= MSTATUS_MPP;
        end else if (we_mstatus) begin
            mstatus <= (csr_wdata & MSTATUS_WMASK) | MSTATUS_MPP;
        end else if (trap_en) begin
            mstatus[csr_pkg::MSTATUS_MPIE_BIT] <= mstatus[csr_pkg::MSTATUS_MIE_BIT];
            mstatus[csr_pkg::MSTATUS_MIE_BIT]  <= 1'b0;
        end else if (ret_en) begin
            mstatus[csr_pkg::MSTATUS_MIE_BIT]  <= mstatus[csr_pkg::MSTATUS_MPIE_BIT];
            mstatus[csr_pkg::MSTATUS_MPIE_BIT] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mepc <= '0;
        end else if (we_mepc) begin
            mepc <= csr_wdata;
        end else if (trap_en) begin
            mepc <= inst_addr;
        end
    end

    // ecall before ebreak before timer
    always_ff @(posedge clk) begin
        if (rst) begin
            mcause <= '0;
        end else if (we_mcause) begin
            mcause <= csr_wdata;
        end else if (trap_en) begin
            if (inst_ecall) begin
                mcause <= XLEN'(csr_pkg::CAUSE_ECALL_M);
            end else if (inst_ebreak) begin
                mcause <= XLEN'(csr_pkg::CAUSE_BREAKPOINT);
            end else if (clint_mtip) begin
                mcause <= MTIMER_CAUSE;
            end
        end
    end

    // mtip is sticky until software clears it
    always_ff @(posedge clk) begin
        if (rst) begin
            mip <= '0;
        end else if (we_mip) begin
            mip <= csr_wdata & MTIP_MASK;
        end else if (clint_mtip) begin
            mip[csr_pkg::MIP_MTIP_BIT] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec    <= '0;
            mie      <= MTIE_MASK;
            mscratch <= '0;
        end else begin
            if (we_mtvec) begin
                mtvec <= csr_wdata;
            end
            if (we_mie) begin
                mie <= csr_wdata & MTIE_MASK;
            end
            if (we_mscratch) begin
                mscratch <= csr_wdata;
            end
        end
    end

    always_comb begin
        case (csr_index)
            csr_pkg::CSR_MSTATUS:   csr_read = mstatus;
            csr_pkg::CSR_MISA:      csr_read = MISA_VAL;
            csr_pkg::CSR_MIE:       csr_read = mie;
            csr_pkg::CSR_MTVEC:     csr_read = mtvec;
            csr_pkg::CSR_MSCRATCH:  csr_read = mscratch;
            csr_pkg::CSR_MEPC:      csr_read = mepc;
            csr_pkg::CSR_MCAUSE:    csr_read = mcause;
            csr_pkg::CSR_MIP:       csr_read = mip;
            csr_pkg::CSR_MCYCLE:    csr_read = mcycle;
            csr_pkg::CSR_MINSTRET:  csr_read = minstret;
            csr_pkg::CSR_MVENDORID: csr_read = '0;
            csr_pkg::CSR_MARCHID:   csr_read = XLEN'(1);
            csr_pkg::CSR_MIMPID:    csr_read = '0;
            csr_pkg::CSR_MHARTID:   csr_read = '0;
            default:                csr_read = '0;
        endcase
    end

    assign csr_trap = mstatus[csr_pkg::MSTATUS_MIE_BIT] && mie[csr_pkg::MIE_MTIE_BIT]
                      && clint_mtip;
    assign csr_epc  = mepc;
    // direct mode only
    assign csr_tvec = {mtvec[XLEN-1:2], 2'b00};

    // decode never flags a trap and an mret on the same instruction
    a_trap_mret_excl: assert property (@(posedge clk) disable iff (rst)
        inst_valid |-> !(inst_trap && inst_mret))
        else $error("csr_regfile: trap and mret together");

    a_mip_bits: assert property (@(posedge clk) disable iff (rst)
        (mip & ~MTIP_MASK) == '0)
        else $error("csr_regfile: mip holds bits other than mtip");

endmodule

`default_nettype wire

// File: hw/csr_top.sv
`timescale 1ns/1ps
`default_nettype none

module csr_top #(
    parameter int XLEN = 32
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_valid,
    input  logic [11:0]         csr_index,
    input  csr_pkg::csr_op_e    csr_op,
    input  logic [XLEN-1:0]     rs1_data,
    input  logic [XLEN-1:0]     imm_csr,
    input  logic                csr_src,
    input  logic [XLEN-1:0]     inst_addr,
    input  logic                inst_trap,
    input  logic                inst_ecall,
    input  logic                inst_ebreak,
    input  logic                inst_mret,
    input  logic                clint_mtip,
    output logic [XLEN-1:0]     csr_read,
    output logic                csr_trap,
    output logic [XLEN-1:0]     csr_epc,
    output logic [XLEN-1:0]     csr_tvec
);

    logic            csr_we;
    logic [XLEN-1:0] csr_wdata;
    logic [XLEN-1:0] mcycle;
    logic [XLEN-1:0] minstret;

    csr_access #(
        .XLEN(XLEN)
    ) u_access (
        .csr_op     (csr_op),
        .csr_src    (csr_src),
        .rs1_data   (rs1_data),
        .imm_csr    (imm_csr),
        .csr_read   (csr_read),
        .inst_valid (inst_valid),
        .csr_we     (csr_we),
        .csr_wdata  (csr_wdata)
    );

    csr_counters #(
        .XLEN(XLEN)
    ) u_counters (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .csr_we     (csr_we),
        .csr_index  (csr_index),
        .csr_wdata  (csr_wdata),
        .mcycle     (mcycle),
        .minstret   (minstret)
    );

    csr_regfile #(
        .XLEN(XLEN)
    ) u_regfile (
        .clk         (clk),
        .rst         (rst),
        .inst_valid  (inst_valid),
        .csr_index   (csr_index),
        .csr_we      (csr_we),
        .csr_wdata   (csr_wdata),
        .inst_addr   (inst_addr),
        .inst_trap   (inst_trap),
        .inst_ecall  (inst_ecall),
        .inst_ebreak (inst_ebreak),
        .inst_mret   (inst_mret),
        .clint_mtip  (clint_mtip),
        .mcycle      (mcycle),
        .minstret    (minstret),
        .csr_read    (csr_read),
        .csr_trap    (csr_trap),
        .csr_epc     (csr_epc),
        .csr_tvec    (csr_tvec)
    );

endmodule

`default_nettype wire

// File: tb/tb_csr_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csr_top;

    localparam int XLEN = 32;

    logic             clk;
    logic             rst;
    logic             inst_valid;
    logic [11:0]      csr_index;
    csr_pkg::csr_op_e csr_op;
    logic [XLEN-1:0]  rs1_data;
    logic [XLEN-1:0]  imm_csr;
    logic             csr_src;
    logic [XLEN-1:0]  inst_addr;
    logic             inst_trap;
    logic             inst_ecall;
    logic             inst_ebreak;
    logic             inst_mret;
    logic             clint_mtip;
    logic [XLEN-1:0]  csr_read;
    logic             csr_trap;
    logic [XLEN-1:0]  csr_epc;
    logic [XLEN-1:0]  csr_tvec;

    logic [31:0] lfsr_state;
    int          n_checks;
    int          n_errors;
    int          edge_count;
    int          sample_edge;
    // reference copy of mstatus.MIE and MPIE
    logic        mie_bit;
    logic        mpie_bit;

    csr_top #(
        .XLEN(XLEN)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .inst_valid  (inst_valid),
        .csr_index   (csr_index),
        .csr_op      (csr_op),
        .rs1_data    (rs1_data),
        .imm_csr     (imm_csr),
        .csr_src     (csr_src),
        .inst_addr   (inst_addr),
        .inst_trap   (inst_trap),
        .inst_ecall  (inst_ecall),
        .inst_ebreak (inst_ebreak),
        .inst_mret   (inst_mret),
        .clint_mtip  (clint_mtip),
        .csr_read    (csr_read),
        .csr_trap    (csr_trap),
        .csr_epc     (csr_epc),
        .csr_tvec    (csr_tvec)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    // taps x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] mstatus_expect();
        return (32'(csr_pkg::MSTATUS_RESET_MPP) << 11)
               | (32'(mpie_bit) << csr_pkg::MSTATUS_MPIE_BIT)
               | (32'(mie_bit) << csr_pkg::MSTATUS_MIE_BIT);
    endfunction

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("ERR %s: got %h expected %h", name, actual, expected);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_inputs();
        inst_valid  = 1'b0;
        csr_op      = csr_pkg::CSR_NONE;
        csr_src     = 1'b0;
        rs1_data    = '0;
        imm_csr     = '0;
        inst_addr   = '0;
        inst_trap   = 1'b0;
        inst_ecall  = 1'b0;
        inst_ebreak = 1'b0;
        inst_mret   = 1'b0;
    endtask

    // one csr instruction that lands at the next edge
    task automatic csr_cycle(input csr_pkg::csr_op_e op, input logic [11:0] idx,
                             input logic src, input logic [31:0] value);
        inst_valid = 1'b1;
        csr_op     = op;
        csr_index  = idx;
        csr_src    = src;
        rs1_data   = src ? '0 : value;
        imm_csr    = src ? value : '0;
        next_cycle();
        idle_inputs();
    endtask

    // sampled mid cycle away from both edges
    task automatic read_csr(input logic [11:0] idx, output logic [31:0] value);
        csr_index = idx;
        #2;
        value = csr_read;
        sample_edge = edge_count;
        next_cycle();
    endtask

    task automatic expect_csr(input string name, input logic [11:0] idx,
                              input logic [31:0] expected);
        logic [31:0] value;
        read_csr(idx, value);
        compare_value(name, value, expected);
    endtask

    task automatic take_trap(input logic ecall, input logic ebreak, input logic [31:0] addr);
        inst_valid  = 1'b1;
        inst_trap   = 1'b1;
        inst_ecall  = ecall;
        inst_ebreak = ebreak;
        inst_addr   = addr;
        next_cycle();
        idle_inputs();
        mpie_bit = mie_bit;
        mie_bit  = 1'b0;
    endtask

    task automatic do_mret();
        inst_valid = 1'b1;
        inst_mret  = 1'b1;
        next_cycle();
        idle_inputs();
        mie_bit  = mpie_bit;
        mpie_bit = 1'b1;
    endtask

    task automatic wait_for_trap(input logic level, input int limit);
        int i;
        i = 0;
        while (csr_trap !== level && i < limit) begin
            next_cycle();
            i++;
        end
        n_checks++;
        if (csr_trap !== level) begin
            n_errors++;
            $display("timeout: csr_trap did not reach %0b within %0d cycles", level, limit);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %s done, %0d errors", name, n_errors - errs_before);
    endtask

    task automatic reset_and_identity();
        int          errs;
        logic [11:0] id_addr[5];
        logic [31:0] id_val[5];
        errs = n_errors;
        id_addr = '{csr_pkg::CSR_MISA, csr_pkg::CSR_MVENDORID, csr_pkg::CSR_MARCHID,
                    csr_pkg::CSR_MIMPID, csr_pkg::CSR_MHARTID};
        // RV32 with the I base only
        id_val = '{(32'd1 << 30) | (32'd1 << 8), 32'd0, 32'd1, 32'd0, 32'd0};
        expect_csr("mstatus", csr_pkg::CSR_MSTATUS, mstatus_expect());
        expect_csr("mie", csr_pkg::CSR_MIE, 32'd1 << csr_pkg::MIE_MTIE_BIT);
        expect_csr("mip", csr_pkg::CSR_MIP, '0);
        expect_csr("mepc", csr_pkg::CSR_MEPC, '0);
        expect_csr("unmapped", 12'h7c0, '0);
        compare_value("csr_trap", 32'(csr_trap), '0);
        for (int i = 0; i < 5; i++) begin
            expect_csr("identity", id_addr[i], id_val[i]);
            csr_cycle(csr_pkg::CSR_RW, id_addr[i], 1'b0, rand_bits(32));
            expect_csr("identity after write", id_addr[i], id_val[i]);
        end
        report_test("reset_and_identity", errs);
    endtask

    task automatic rmw_ops();
        int               errs;
        logic [31:0]      mscratch_m;
        logic [31:0]      mtvec_m;
        logic [31:0]      old;
        logic [31:0]      opnd;
        logic [31:0]      result;
        logic [11:0]      idx;
        logic             src;
        csr_pkg::csr_op_e op;
        errs = n_errors;
        mscratch_m = '0;
        mtvec_m = '0;
        for (int k = 0; k < 12; k++) begin
            idx = (k < 6) ? csr_pkg::CSR_MSCRATCH : csr_pkg::CSR_MTVEC;
            op = (k % 3 == 0) ? csr_pkg::CSR_RW : (k % 3 == 1) ? csr_pkg::CSR_RS : csr_pkg::CSR_RC;
            src = (k % 6) >= 3;
            // immediate form carries a 5-bit zimm
            opnd = src ? rand_bits(5) : rand_bits(32);
            old = (k < 6) ? mscratch_m : mtvec_m;
            if (op == csr_pkg::CSR_RW) begin
                result = opnd;
            end else if (op == csr_pkg::CSR_RS) begin
                result = old | opnd;
            end else begin
                result = old & ~opnd;
            end
            if (k < 6) begin
                mscratch_m = result;
            end else begin
                mtvec_m = result;
            end
            csr_cycle(op, idx, src, opnd);
            expect_csr((k < 6) ? "mscratch" : "mtvec", idx, result);
            if (k >= 6) begin
                compare_value("csr_tvec", csr_tvec, result & ~32'h3);
            end
        end
        report_test("rmw_ops", errs);
    endtask

    task automatic sync_traps();
        int          errs;
        logic [31:0] addr;
        errs = n_errors;
        csr_cycle(csr_pkg::CSR_RW, csr_pkg::CSR_MSTATUS, 1'b0, 32'd1 << csr_pkg::MSTATUS_MIE_BIT);
        mie_bit  = 1'b1;
        mpie_bit = 1'b0;
        expect_csr("mstatus", csr_pkg::CSR_MSTATUS, mstatus_expect());
        addr = rand_bits(32) & ~32'h3;
        take_trap(1'b1, 1'b0, addr);
        expect_csr("mepc", csr_pkg::CSR_MEPC, addr);
        compare_value("csr_epc", csr_epc, addr);
        expect_csr("mcause", csr_pkg::CSR_MCAUSE, csr_pkg::CAUSE_ECALL_M);
        expect_csr("mstatus", csr_pkg::CSR_MSTATUS, mstatus_expect());
        do_mret();
        expect_csr("mstatus", csr_pkg::CSR_MSTATUS, mstatus_expect());
        // MIE low so the next trap leaves MPIE clear before mret
        csr_cycle(csr_pkg::CSR_RC, csr_pkg::CSR_MSTATUS, 1'b0, 32'd1 << csr_pkg::MSTATUS_MIE_BIT);
        mie_bit = 1'b0;
        expect_csr("mstatus", csr_pkg::CSR_MSTATUS, mstatus_expect());
        addr = rand_bits(32) & ~32'h3;
        take_trap(1'b0, 1'b1, addr);
        expect_csr("mepc", csr_pkg::CSR_MEPC, addr);
        compare_value("csr_epc", csr_epc, addr);
        expect_csr("mcause", csr_pkg::CSR_MCAUSE, csr_pkg::CAUSE_BREAKPOINT);
        expect_csr("mstatus", csr_pkg::CSR_MSTATUS, mstatus_expect());
        do_mret();
        expect_csr("mstatus", csr_pkg::CSR_MSTATUS, mstatus_expect());
        report_test("sync_traps", errs);
    endtask

    task automatic timer_irq();
        int          errs;
        logic [31:0] mtip_mask;
        errs = n_errors;
        mtip_mask = 32'd1 << csr_pkg::MIP_MTIP_BIT;
        csr_cycle(csr_pkg::CSR_RW, csr_pkg::CSR_MSTATUS, 1'b0, '0);
        mie_bit  = 1'b0;
        mpie_bit = 1'b0;
        clint_mtip = 1'b1;
        next_cycle();
        expect_csr("mip", csr_pkg::CSR_MIP, mtip_mask);
        compare_value("csr_trap", 32'(csr_trap), '0);
        csr_cycle(csr_pkg::CSR_RS, csr_pkg::CSR_MSTATUS, 1'b0, 32'd1 << csr_pkg::MSTATUS_MIE_BIT);
        mie_bit = 1'b1;
        wait_for_trap(1'b1, 4);
        csr_cycle(csr_pkg::CSR_RC, csr_pkg::CSR_MIE, 1'b0, 32'd1 << csr_pkg::MIE_MTIE_BIT);
        wait_for_trap(1'b0, 4);
        csr_cycle(csr_pkg::CSR_RS, csr_pkg::CSR_MIE, 1'b0, 32'd1 << csr_pkg::MIE_MTIE_BIT);
        wait_for_trap(1'b1, 4);
        clint_mtip = 1'b0;
        #1;
        compare_value("csr_trap", 32'(csr_trap), '0);
        // mtip stays pending after the line drops
        expect_csr("mip", csr_pkg::CSR_MIP, mtip_mask);
        clint_mtip = 1'b1;
        take_trap(1'b0, 1'b0, rand_bits(32) & ~32'h3);
        expect_csr("mcause", csr_pkg::CSR_MCAUSE,
                   (32'd1 << 31) | 32'(csr_pkg::CAUSE_MTIMER_CODE));
        compare_value("csr_trap", 32'(csr_trap), '0);
        clint_mtip = 1'b0;
        csr_cycle(csr_pkg::CSR_RW, csr_pkg::CSR_MIP, 1'b0, '0);
        expect_csr("mip", csr_pkg::CSR_MIP, '0);
        report_test("timer_irq", errs);
    endtask

    task automatic counter_growth();
        int          errs;
        int          n;
        int          e0;
        logic [31:0] v0;
        logic [31:0] v1;
        logic [31:0] wval;
        errs = n_errors;
        read_csr(csr_pkg::CSR_MINSTRET, v0);
        n = 3 + rand_bits(3);
        for (int i = 0; i < n; i++) begin
            inst_valid = 1'b1;
            next_cycle();
        end
        idle_inputs();
        read_csr(csr_pkg::CSR_MINSTRET, v1);
        compare_value("minstret delta", v1 - v0, n);
        read_csr(csr_pkg::CSR_MCYCLE, v0);
        e0 = sample_edge;
        repeat (2 + rand_bits(3)) next_cycle();
        read_csr(csr_pkg::CSR_MCYCLE, v1);
        compare_value("mcycle delta", v1 - v0, sample_edge - e0);
        wval = rand_bits(32);
        csr_cycle(csr_pkg::CSR_RW, csr_pkg::CSR_MCYCLE, 1'b0, wval);
        e0 = edge_count;
        read_csr(csr_pkg::CSR_MCYCLE, v1);
        compare_value("mcycle", v1, wval + (sample_edge - e0));
        wval = rand_bits(32);
        csr_cycle(csr_pkg::CSR_RW, csr_pkg::CSR_MINSTRET, 1'b0, wval);
        // the read itself is not a valid instruction
        expect_csr("minstret", csr_pkg::CSR_MINSTRET, wval);
        report_test("counter_growth", errs);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        csr_index  = '0;
        clint_mtip = 1'b0;
        idle_inputs();
        lfsr_state = 32'ha977d5df;
        n_checks = 0;
        n_errors = 0;
        edge_count = 0;
        sample_edge = 0;
        mie_bit  = 1'b0;
        mpie_bit = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        next_cycle();
        reset_and_identity();
        rmw_ops();
        sync_traps();
        timer_irq();
        counter_growth();
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
